// ==== bench/tb_zx_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_zx_timing import zx_timing_pkg::*; ();

  // one whole frame in master cycles, plus some margin
  localparam int FRAME_CYCLES = 4 * H_TOTAL * V_TOTAL + 64;

  logic            clk;
  logic            rst_n;
  logic            io_wr;
  logic            cpu_mreq;
  logic [15:0]     io_addr;
  logic [15:0]     cpu_addr;
  logic [7:0]      io_data;
  logic            clk14en;
  logic            clk7en;
  logic            clk7en_n;
  logic            clk35en;
  logic            clk35en_n;
  logic            clk175en;
  logic            clkcpu_enable;
  logic            int_n;
  logic [HC_W-1:0] hc;
  logic [VC_W-1:0] vc;

  // master cycles since reset release, cycle 0 is the first one with rst_n high
  int         cyc;
  int         errors;
  int         errs_before;
  int         tests_run;
  int         tests_failed;
  // reference contended accesses that met a 3.5 MHz phase
  int         cont_hits;
  logic [3:0] speed_model;
  logic [31:0] rng;

  // state of the comparing process
  int         phase;
  int         ref_h;
  int         ref_v;
  logic [5:0] fixed;
  logic       cont;

  zx_timing_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .io_wr         (io_wr),
    .cpu_mreq      (cpu_mreq),
    .io_addr       (io_addr),
    .cpu_addr      (cpu_addr),
    .io_data       (io_data),
    .clk14en       (clk14en),
    .clk7en        (clk7en),
    .clk7en_n      (clk7en_n),
    .clk35en       (clk35en),
    .clk35en_n     (clk35en_n),
    .clk175en      (clk175en),
    .clkcpu_enable (clkcpu_enable),
    .int_n         (int_n),
    .hc            (hc),
    .vc            (vc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // bit order is clk14en, clk7en, clk7en_n, clk35en, clk35en_n, clk175en
  function automatic logic [5:0] ref_fixed(input int p);
    return {p % 2 == 0, p % 4 == 0, p % 4 == 2, p % 8 == 0, p % 8 == 7, p == 0};
  endfunction

  // pixel clocks seen before cycle n, one per 7 MHz strobe at n mod 4 == 0
  function automatic int ref_pixels(input int n);
    return (n + 3) / 4;
  endfunction

  function automatic int ref_hc(input int n);
    return ref_pixels(n) % H_TOTAL;
  endfunction

  function automatic int ref_vc(input int n);
    return (ref_pixels(n) / H_TOTAL) % V_TOTAL;
  endfunction

  function automatic logic ref_int_n(input int h, input int v);
    return !((v == INT_LINE) && (h < INT_WIDTH));
  endfunction

  function automatic logic ref_contention(input logic [15:0] addr, input logic mreq,
                                          input int h, input int v);
    return mreq && (addr[15:14] == CONT_BANK) && (v < V_DISPLAY) &&
           (h < H_DISPLAY) && (h % 8 < 6);
  endfunction

  function automatic logic ref_cpu_enable(input logic [3:0] speed, input int p,
                                          input logic c);
    if (speed[2]) begin
      return 1'b1;
    end
    case (speed)
      SPEED_3M5: return (p % 8 == 0) && !c;
      SPEED_7M:  return p % 4 == 0;
      SPEED_14M: return p % 2 == 0;
      SPEED_28M: return 1'b1;
      default:   return 1'b0;
    endcase
  endfunction

  // CPU strobes in one ring period without contention
  function automatic int ref_strobes(input logic [3:0] code);
    return code[2] ? 16 : (2 << code[1:0]);
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got %0h expected %0h at cycle %0d", name, actual, expected, cyc);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
  endtask

  // a write cycle, the new code is live from the cycle after it
  task automatic write_port(input logic [15:0] addr, input logic [7:0] data);
    io_addr = addr;
    io_data = data;
    io_wr   = 1'b1;
    @(negedge clk);
    io_wr   = 1'b0;
  endtask

  task automatic count_cpu_strobes(output int cnt);
    cnt = 0;
    repeat (RING_LEN) begin
      @(posedge clk);
      if (clkcpu_enable) cnt++;
    end
    @(negedge clk);
  endtask

  task automatic drive_random_accesses(input int n);
    repeat (n) begin
      rng = lcg_step(rng);
      cpu_addr = rng[31:16];
      @(negedge clk);
    end
  endtask

  // waited counts the samples that did not match yet
  task automatic wait_int_level(input logic level, input int limit,
                                output int waited, output bit ok);
    waited = 0;
    ok = 1'b0;
    while (!ok && waited < limit) begin
      @(posedge clk);
      if (int_n === level) ok = 1'b1;
      else waited++;
    end
    @(negedge clk);
  endtask

  task automatic wait_frame_start(input int limit, output bit ok);
    int waited;
    waited = 0;
    ok = 1'b0;
    while (!ok && waited < limit) begin
      @(posedge clk);
      if (hc == '0 && vc == '0) ok = 1'b1;
      else waited++;
    end
    @(negedge clk);
  endtask

  task automatic start_test();
    errs_before = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  // every output is compared on each rising edge against the model of cycle cyc
  always @(posedge clk) begin
    if (!rst_n) begin
      cyc = 0;
      speed_model = SPEED_3M5;
    end else begin
      phase = cyc % RING_LEN;
      fixed = ref_fixed(phase);
      ref_h = ref_hc(cyc);
      ref_v = ref_vc(cyc);
      cont  = ref_contention(cpu_addr, cpu_mreq, ref_h, ref_v);
      check_value("clk14en", 32'(clk14en), 32'(fixed[5]));
      check_value("clk7en", 32'(clk7en), 32'(fixed[4]));
      check_value("clk7en_n", 32'(clk7en_n), 32'(fixed[3]));
      check_value("clk35en", 32'(clk35en), 32'(fixed[2]));
      check_value("clk35en_n", 32'(clk35en_n), 32'(fixed[1]));
      check_value("clk175en", 32'(clk175en), 32'(fixed[0]));
      check_value("hc", 32'(hc), 32'(ref_h));
      check_value("vc", 32'(vc), 32'(ref_v));
      check_value("int_n", 32'(int_n), 32'(ref_int_n(ref_h, ref_v)));
      check_value("clkcpu_enable", 32'(clkcpu_enable),
                  32'(ref_cpu_enable(speed_model, phase, cont)));
      if (cont && (phase % 8 == 0)) cont_hits++;
      // the speed register takes a matching write at this edge
      if (io_wr && io_addr == TURBO_PORT) speed_model = io_data[3:0];
      cyc++;
    end
  end

  initial begin
    int          code;
    int          i;
    int          strobes;
    int          waited;
    int          hits_start;
    bit          ok;
    logic [15:0] addr;
    logic [31:0] seed_saved;
    rst_n = 1'b0;
    io_wr = 1'b0;
    io_addr = '0;
    io_data = '0;
    cpu_addr = '0;
    cpu_mreq = 1'b0;
    errors = 0;
    errs_before = 0;
    tests_run = 0;
    tests_failed = 0;
    cont_hits = 0;
    cyc = 0;
    speed_model = SPEED_3M5;
    rng = 32'h34fa_b758;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle ring periods, the comparing process checks every phase
    start_test();
    repeat (4 * RING_LEN) @(negedge clk);
    end_test("fixed enables");

    start_test();
    for (code = 0; code < 8; code++) begin
      write_port(TURBO_PORT, 8'(code));
      count_cpu_strobes(strobes);
      check_value("cpu_strobes", 32'(strobes), 32'(ref_strobes(4'(code))));
    end
    end_test("speed changes");

    start_test();
    write_port(TURBO_PORT, {4'h0, SPEED_14M});
    for (i = 0; i < 16; i++) begin
      rng = lcg_step(rng);
      addr = rng[31:16];
      if (addr == TURBO_PORT) addr = ~addr;
      rng = lcg_step(rng);
      if (i % 4 == 3) begin
        // turbo port on the bus but no write strobe
        io_addr = TURBO_PORT;
        io_data = rng[23:16];
        @(negedge clk);
      end else begin
        write_port(addr, rng[23:16]);
      end
      count_cpu_strobes(strobes);
      check_value("cpu_strobes", 32'(strobes), 32'(ref_strobes(SPEED_14M)));
    end
    end_test("ignored writes");

    // the beam is still in the first display lines here
    start_test();
    write_port(TURBO_PORT, {4'h0, SPEED_3M5});
    cpu_mreq = 1'b1;
    seed_saved = rng;
    hits_start = cont_hits;
    drive_random_accesses(1600);
    if (cont_hits == hits_start) begin
      $display("no contended access met a 3.5 MHz strobe at speed code 0");
      errors++;
    end
    // same address sequence again at 7 MHz, where contention is ignored
    write_port(TURBO_PORT, {4'h0, SPEED_7M});
    rng = seed_saved;
    hits_start = cont_hits;
    drive_random_accesses(1600);
    if (cont_hits == hits_start) begin
      $display("no contended access met a 3.5 MHz phase at speed code 1");
      errors++;
    end
    cpu_mreq = 1'b0;
    cpu_addr = '0;
    end_test("contention");

    // run to the interrupt line and then on to the frame wrap
    start_test();
    wait_int_level(1'b0, FRAME_CYCLES, waited, ok);
    if (!ok) begin
      report_timeout("int_n to fall");
    end else begin
      wait_int_level(1'b1, 8 * INT_WIDTH, waited, ok);
      if (!ok) report_timeout("int_n to rise");
      else check_value("int_low_cycles", 32'(waited + 1), 32'(4 * INT_WIDTH));
    end
    wait_frame_start(FRAME_CYCLES, ok);
    if (!ok) report_timeout("the frame to wrap");
    end_test("video counters");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/zx_timing_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_timing_props import zx_timing_pkg::*; (
  input logic                clk,
  input logic                rst_n,
  input logic [RING_LEN-1:0] ring,
  input logic                clk7en,
  input logic                clk7en_n,
  input logic                clk175en,
  input logic                clkcpu_enable,
  input logic [3:0]          cpu_speed
);

  // exactly one stage of the ring is active at any time
  ring_one_hot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(ring))
    else $error("ring is not one-hot");

  // the two 7 MHz phases are half a period apart
  clk7_phases_apart: assert property (@(posedge clk) disable iff (!rst_n)
    !(clk7en && clk7en_n))
    else $error("clk7en and clk7en_n are high together");

  // 1.75 MHz strobe comes back once per ring period
  clk175_period: assert property (@(posedge clk) disable iff (!rst_n)
    clk175en |-> ##RING_LEN clk175en)
    else $error("clk175en did not recur after a ring period");

  // unlimited speed never drops the CPU enable
  cpu_full_speed: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_speed[2] |-> clkcpu_enable)
    else $error("clkcpu_enable low at unlimited speed");

endmodule

bind clk_enables zx_timing_props props0 (
  .clk           (clk),
  .rst_n         (rst_n),
  .ring          (ring),
  .clk7en        (clk7en),
  .clk7en_n      (clk7en_n),
  .clk175en      (clk175en),
  .clkcpu_enable (clkcpu_enable),
  .cpu_speed     (cpu_speed)
);

`default_nettype wire

// ==== flist.f ====
rtl/zx_timing_pkg.sv
rtl/clk_enables.sv
rtl/video_counters.sv
rtl/contention.sv
rtl/speed_reg.sv
rtl/zx_timing_top.sv
bench/zx_timing_props.sv
bench/tb_zx_timing.sv

// ==== rtl/clk_enables.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_enables import zx_timing_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cpu_contention,
  input  logic [3:0] cpu_speed,
  output logic       clk14en,
  output logic       clk7en,
  output logic       clk7en_n,
  output logic       clk35en,
  output logic       clk35en_n,
  output logic       clk175en,
  output logic       clkcpu_enable
);

  // one-hot ring where stage k is set in master cycle k of each 1.75 MHz period
  logic [RING_LEN-1:0] ring;

  // reset parks the ring on stage 0 so that every enable lines up on
  // the first cycle after release
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ring <= {{(RING_LEN - 1){1'b0}}, 1'b1};
    end else begin
      // rotate left so that the top stage wraps back into stage 0
      ring <= {ring[RING_LEN-2:0], ring[RING_LEN-1]};
    end
  end

  // 14 MHz lands on every even stage
  assign clk14en = |{ring[14], ring[12], ring[10], ring[8],
                     ring[6], ring[4], ring[2], ring[0]};

  // 7 MHz on every fourth stage starting at 0
  assign clk7en = |{ring[12], ring[8], ring[4], ring[0]};

  // the inverted 7 MHz phase sits halfway between the clk7en strobes
  assign clk7en_n = |{ring[14], ring[10], ring[6], ring[2]};

  // 3.5 MHz twice per ring period
  assign clk35en = ring[8] | ring[0];

  // the inverted 3.5 MHz phase comes one master cycle ahead of each clk35en strobe
  assign clk35en_n = ring[15] | ring[7];

  // 1.75 MHz once per ring period
  assign clk175en = ring[0];

  // CPU enable selected by the speed code
  // contention only stretches the CPU at the original 3.5 MHz rate
  // while the faster modes ignore it and simply run through
  always_comb begin
    if (cpu_speed[2]) begin
      // at unlimited speed the CPU steps every master clock
      clkcpu_enable = 1'b1;
    end else begin
      case (cpu_speed)
        // the 28 MHz rate is the master clock itself
        SPEED_28M: clkcpu_enable = 1'b1;
        SPEED_14M: clkcpu_enable = clk14en;
        SPEED_7M:  clkcpu_enable = clk7en;
        SPEED_3M5: clkcpu_enable = clk35en & ~cpu_contention;
        // codes with bit 3 set and bit 2 clear are not defined, so the
        // CPU is held until a valid code is written
        default:   clkcpu_enable = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/contention.sv ====
`timescale 1ns/1ps
`default_nettype none

module contention import zx_timing_pkg::*; (
  input  logic [15:0]     cpu_addr,
  input  logic            cpu_mreq,
  input  logic [HC_W-1:0] hc,
  input  logic [VC_W-1:0] vc,
  output logic            cpu_contention
);

  // the access targets the bank that the video fetch shares
  logic in_bank;

  // the beam is inside the visible paper area
  logic in_window;

  // phase within the eight pixel-clock fetch group
  logic [2:0] fetch_phase;

  // the ULA owns the bus during six of every eight pixel clocks
  logic hold_phase;

  assign in_bank = (cpu_addr[15:14] == CONT_BANK);

  // border lines and the right border and retrace are free of fetches
  assign in_window = (vc < VC_W'(V_DISPLAY)) && (hc < HC_W'(H_DISPLAY));

  assign fetch_phase = hc[2:0];

  // phases 6 and 7 leave the bus to the CPU
  assign hold_phase = (fetch_phase < 3'd6);

  // combined hold-off request
  // the speed is not looked at here, only the CPU enable logic knows
  // whether the current rate is affected by contention
  assign cpu_contention = cpu_mreq & in_bank & in_window & hold_phase;

endmodule

`default_nettype wire

// ==== rtl/speed_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module speed_reg import zx_timing_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        io_wr,
  input  logic [15:0] io_addr,
  input  logic [7:0]  io_data,
  output logic [3:0]  cpu_speed
);

  // full 16-bit port decode, so mirrors of the turbo port are not taken
  logic port_hit;

  assign port_hit = io_wr && (io_addr == TURBO_PORT);

  // only the low nibble holds the speed code, the upper bits of the
  // written byte have no meaning here
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // the machine comes up at the original 3.5 MHz rate
      cpu_speed <= SPEED_3M5;
    end else if (port_hit) begin
      cpu_speed <= io_data[3:0];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/video_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_counters import zx_timing_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            clk7en,
  output logic [HC_W-1:0] hc,
  output logic [VC_W-1:0] vc,
  output logic            int_n
);

  // last count of each counter before it wraps
  localparam logic [HC_W-1:0] HC_LAST = HC_W'(H_TOTAL - 1);
  localparam logic [VC_W-1:0] VC_LAST = VC_W'(V_TOTAL - 1);

  // next beam position, worked out one cycle ahead so the interrupt
  // register can follow the counters without lagging them
  logic [HC_W-1:0] hc_next;
  logic [VC_W-1:0] vc_next;

  // high when the next position falls inside the interrupt pulse
  logic int_active_next;

  // hc_wrap marks the last pixel clock of a line
  logic hc_wrap;

  assign hc_wrap = (hc == HC_LAST);

  always_comb begin
    hc_next = hc;
    vc_next = vc;
    if (clk7en) begin
      if (hc_wrap) begin
        hc_next = '0;
        // the line counter steps only when a line is finished
        if (vc == VC_LAST) begin
          vc_next = '0;
        end else begin
          vc_next = vc + 1'b1;
        end
      end else begin
        hc_next = hc + 1'b1;
      end
    end
  end

  // the pulse covers the first INT_WIDTH pixel clocks of INT_LINE
  assign int_active_next = (vc_next == VC_W'(INT_LINE)) &&
                           (hc_next < HC_W'(INT_WIDTH));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hc <= '0;
      vc <= '0;
    end else begin
      hc <= hc_next;
      vc <= vc_next;
    end
  end

  // registered active-low interrupt
  // it is computed from the next position, so it is low on exactly the
  // cycles in which hc and vc show the interrupt window
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      int_n <= 1'b1;
    end else begin
      int_n <= ~int_active_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/zx_timing_pkg.sv ====
`default_nettype none

package zx_timing_pkg;

  // master clocks in one 1.75 MHz period, one ring stage per master clock
  localparam int RING_LEN = 16;

  // horizontal geometry in 7 MHz pixel clocks
  localparam int H_TOTAL   = 448;
  localparam int H_DISPLAY = 256;

  // vertical geometry in lines
  localparam int V_TOTAL   = 312;
  localparam int V_DISPLAY = 192;

  // the frame interrupt is held low at the start of this line
  localparam int INT_LINE  = 248;
  // length of the low interrupt pulse in pixel clocks
  localparam int INT_WIDTH = 32;

  // both counters need nine bits to reach 447 and 311
  localparam int HC_W = 9;
  localparam int VC_W = 9;

  // CPU speed codes, any code with bit 2 set runs at the full master rate
  localparam logic [3:0] SPEED_3M5 = 4'd0;
  localparam logic [3:0] SPEED_7M  = 4'd1;
  localparam logic [3:0] SPEED_14M = 4'd2;
  localparam logic [3:0] SPEED_28M = 4'd3;

  // I/O address of the turbo register
  localparam logic [15:0] TURBO_PORT = 16'h003B;

  // address bits 15:14 of the contended 16 KB bank
  localparam logic [1:0] CONT_BANK = 2'b01;

endpackage

`default_nettype wire

// ==== rtl/zx_timing_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_timing_top import zx_timing_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            io_wr,
  input  logic            cpu_mreq,
  input  logic [15:0]     io_addr,
  input  logic [15:0]     cpu_addr,
  input  logic [7:0]      io_data,
  output logic            clk14en,
  output logic            clk7en,
  output logic            clk7en_n,
  output logic            clk35en,
  output logic            clk35en_n,
  output logic            clk175en,
  output logic            clkcpu_enable,
  output logic            int_n,
  output logic [HC_W-1:0] hc,
  output logic [VC_W-1:0] vc
);

  // speed code from the turbo register to the CPU enable mux
  logic [3:0] cpu_speed;

  // hold-off request from the contention decoder
  logic cpu_contention;

  // turbo register on the I/O bus
  speed_reg u_speed_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .io_wr     (io_wr),
    .io_addr   (io_addr),
    .io_data   (io_data),
    .cpu_speed (cpu_speed)
  );

  // master ring and every clock enable derived from it
  clk_enables u_clk_enables (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_contention (cpu_contention),
    .cpu_speed      (cpu_speed),
    .clk14en        (clk14en),
    .clk7en         (clk7en),
    .clk7en_n       (clk7en_n),
    .clk35en        (clk35en),
    .clk35en_n      (clk35en_n),
    .clk175en       (clk175en),
    .clkcpu_enable  (clkcpu_enable)
  );

  // beam position advances at the 7 MHz pixel rate
  video_counters u_video_counters (
    .clk    (clk),
    .rst_n  (rst_n),
    .clk7en (clk7en),
    .hc     (hc),
    .vc     (vc),
    .int_n  (int_n)
  );

  // contention looks at the beam position and the current CPU access
  contention u_contention (
    .cpu_addr       (cpu_addr),
    .cpu_mreq       (cpu_mreq),
    .hc             (hc),
    .vc             (vc),
    .cpu_contention (cpu_contention)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the zx timing testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_zx_timing

verilator --binary --timing --assert \
  -f flist.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "run_sim: verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "run_sim: simulation exited with status $run_status"
  exit 1
fi

if grep -qx "All tests passed" "$LOG"; then
  echo "run_sim: simulation passed"
  exit 0
else
  echo "run_sim: simulation failed, see $LOG"
  exit 1
fi
